//--- src/edpPkg.sv
package edpPkg;

  // Machine word, bit 0 is the most significant bit
  localparam int wordWidth = 36;
  typedef logic [0:wordWidth-1] wordT;

  typedef logic [2:0] aluFuncT;
  typedef logic [1:0] adaSelT;
  typedef logic [1:0] adbSelT;
  typedef logic [1:0] mqFuncT;
  typedef logic [1:0] logicSelT;

  // ALU function codes, low bit inverts the B operand
  localparam aluFuncT aluAdd    = 3'b000;
  localparam aluFuncT aluSub    = 3'b001;
  localparam aluFuncT aluAnd    = 3'b010;
  localparam aluFuncT aluAndNot = 3'b011;
  localparam aluFuncT aluOr     = 3'b100;
  localparam aluFuncT aluOrNot  = 3'b101;
  localparam aluFuncT aluXor    = 3'b110;
  localparam aluFuncT aluXnor   = 3'b111;

  localparam adaSelT adaAr   = 2'b00;
  localparam adaSelT adaMq   = 2'b01;
  localparam adaSelT adaBr   = 2'b10;
  localparam adaSelT adaZero = 2'b11;

  localparam adbSelT adbBr   = 2'b00;
  localparam adbSelT adbData = 2'b01;
  localparam adbSelT adbAr   = 2'b10;
  localparam adbSelT adbZero = 2'b11;

  localparam mqFuncT mqHold       = 2'b00;
  localparam mqFuncT mqLoadAd     = 2'b01;
  localparam mqFuncT mqShiftRight = 2'b10;
  localparam mqFuncT mqClear      = 2'b11;

  // Logic unit operations
  localparam logicSelT logicAnd  = 2'b00;
  localparam logicSelT logicOr   = 2'b01;
  localparam logicSelT logicXor  = 2'b10;
  localparam logicSelT logicXnor = 2'b11;

endpackage

//--- src/edpControl.sv
`timescale 1ns/100ps

module edpControl (
  input  logic              eboxClk,
  input  logic              reset,

  input  logic              cmdStrobe,
  input  edpPkg::aluFuncT   cmdAluFunc,
  input  edpPkg::adaSelT    cmdAdaSel,
  input  edpPkg::adbSelT    cmdAdbSel,
  input  logic              cmdArLoad,
  input  logic              cmdBrLoad,
  input  edpPkg::mqFuncT    cmdMqFunc,
  input  edpPkg::wordT      cmdData,

  output edpPkg::adaSelT    adaSel,
  output edpPkg::adbSelT    adbSel,
  output logic              invertB,
  output logic              arith,
  output edpPkg::logicSelT  logicSel,
  output logic              carryIn,
  output logic              arLoad,
  output logic              brLoad,
  output edpPkg::mqFuncT    mqFunc,
  output edpPkg::wordT      opData,
  output logic              execStrobe
);

  import edpPkg::*;

  logic     decArith;
  logic     decCarryIn;
  logicSelT decLogicSel;

  // Function code decode
  always_comb begin
    decArith = (cmdAluFunc == aluAdd) || (cmdAluFunc == aluSub);

    // Subtract is A + ~B + 1
    decCarryIn = (cmdAluFunc == aluSub);

    // High bits pick the logic class, the low bit inverts B,
    // so andNot, orNot and xnor come out of and, or and xor
    case (cmdAluFunc[2:1])
      2'b01:   decLogicSel = logicAnd;
      2'b10:   decLogicSel = logicOr;
      default: decLogicSel = logicXor;
    endcase
  end

  // Operand selects, decoded function and data word
  always_ff @(posedge eboxClk) begin
    if (cmdStrobe) begin
      adaSel   <= cmdAdaSel;
      adbSel   <= cmdAdbSel;
      invertB  <= cmdAluFunc[0];
      arith    <= decArith;
      logicSel <= decLogicSel;
      carryIn  <= decCarryIn;
      opData   <= cmdData;
    end
  end

  // Enables are live for exactly one cycle per strobe
  always_ff @(posedge eboxClk) begin
    if (reset) begin
      arLoad     <= 1'b0;
      brLoad     <= 1'b0;
      mqFunc     <= mqHold;
      execStrobe <= 1'b0;
    end else begin
      arLoad     <= cmdStrobe & cmdArLoad;
      brLoad     <= cmdStrobe & cmdBrLoad;
      execStrobe <= cmdStrobe;
      if (cmdStrobe) begin
        mqFunc <= cmdMqFunc;
      end else begin
        mqFunc <= mqHold;
      end
    end
  end

endmodule

//--- src/edpSlice.sv
`timescale 1ns/100ps

module edpSlice #(
  parameter int sliceWidth = 6
) (
  input  logic                   eboxClk,
  input  logic                   reset,

  input  edpPkg::adaSelT         adaSel,
  input  edpPkg::adbSelT         adbSel,
  input  logic                   invertB,
  input  logic                   arith,
  input  edpPkg::logicSelT       logicSel,
  input  logic                   arLoad,
  input  logic                   brLoad,
  input  edpPkg::mqFuncT         mqFunc,
  input  logic [0:sliceWidth-1]  sliceData,
  input  logic                   sliceCarryIn,
  input  logic                   mqShiftIn,

  output logic                   gen,
  output logic                   prop,
  output logic                   msbCarry,
  output logic [0:sliceWidth-1]  sliceAd,
  output logic                   mqLow
);

  import edpPkg::*;

  // This slice's share of the architectural registers
  logic [0:sliceWidth-1] ar;
  logic [0:sliceWidth-1] br;
  logic [0:sliceWidth-1] mq;

  logic [0:sliceWidth-1] opA;
  logic [0:sliceWidth-1] bSel;
  logic [0:sliceWidth-1] opB;
  logic [0:sliceWidth-1] bitGen;
  logic [0:sliceWidth-1] bitProp;
  logic [0:sliceWidth-1] sum;
  logic [0:sliceWidth-1] logicResult;

  // carry[j] is the carry out of bit j and carry[sliceWidth] is the slice carry in
  logic [1:sliceWidth] carry;

  // A and B operand muxes
  always_comb begin
    case (adaSel)
      adaAr:   opA = ar;
      adaMq:   opA = mq;
      adaBr:   opA = br;
      default: opA = '0;
    endcase
    case (adbSel)
      adbBr:   bSel = br;
      adbData: bSel = sliceData;
      adbAr:   bSel = ar;
      default: bSel = '0;
    endcase
    opB = bSel ^ {sliceWidth{invertB}};
  end

  // Per-bit generate and propagate held low for logic functions
  assign bitGen  = arith ? (opA & opB) : '0;
  assign bitProp = arith ? (opA ^ opB) : '0;

  // Ripple inside the slice from the lookahead carry in
  always_comb begin
    carry[sliceWidth] = sliceCarryIn;
    for (int j = sliceWidth - 1; j >= 1; j--) begin
      carry[j] = bitGen[j] | (bitProp[j] & carry[j+1]);
    end
    for (int j = 0; j < sliceWidth; j++) begin
      sum[j] = bitProp[j] ^ carry[j+1];
    end
  end

  // Only slice 0's value feeds overflow
  assign msbCarry = carry[1];

  // Group terms for the lookahead built from the LSB end
  always_comb begin
    gen  = 1'b0;
    prop = 1'b1;
    for (int j = sliceWidth - 1; j >= 0; j--) begin
      gen  = bitGen[j] | (bitProp[j] & gen);
      prop = prop & bitProp[j];
    end
  end

  // Xnor comes out of xor with B inverted
  always_comb begin
    case (logicSel)
      logicAnd: logicResult = opA & opB;
      logicOr:  logicResult = opA | opB;
      default:  logicResult = opA ^ opB;
    endcase
  end

  assign sliceAd = arith ? sum : logicResult;

  // BR takes AR as it was before this edge
  always_ff @(posedge eboxClk) begin
    if (reset) begin
      ar <= '0;
      br <= '0;
      mq <= '0;
    end else begin
      if (arLoad) begin
        ar <= sliceAd;
      end
      if (brLoad) begin
        br <= ar;
      end
      case (mqFunc)
        mqLoadAd:     mq <= sliceAd;
        mqShiftRight: mq <= {mqShiftIn, mq[0:sliceWidth-2]};
        mqClear:      mq <= '0;
        default:      mq <= mq;
      endcase
    end
  end

  // Feeds the top bit of the next slice down on a shift
  assign mqLow = mq[sliceWidth-1];

endmodule

//--- src/edpLookahead.sv
`timescale 1ns/100ps

module edpLookahead #(
  parameter int sliceWidth = 6
) (
  input  logic                                      eboxClk,
  input  logic                                      reset,

  input  logic [0:edpPkg::wordWidth/sliceWidth-1]   gen,
  input  logic [0:edpPkg::wordWidth/sliceWidth-1]   prop,
  input  logic                                      carryIn,
  input  logic                                      msbCarry,
  input  edpPkg::wordT                              adWord,
  input  logic                                      execStrobe,

  output logic [0:edpPkg::wordWidth/sliceWidth-1]   sliceCarry,
  output logic                                      resultValid,
  output edpPkg::wordT                              resultData,
  output logic                                      resultCarry,
  output logic                                      resultOverflow
);

  import edpPkg::*;

  localparam int nSlices = wordWidth / sliceWidth;

  logic carryOut;

  // Carry out of slices lo..nSlices-1, in sum of products form.
  // With lo equal to nSlices this is just the word carry in
  function automatic logic groupCarry(
    input int                 lo,
    input logic [0:nSlices-1] g,
    input logic [0:nSlices-1] p,
    input logic               cin
  );
    logic acc;
    logic pathProp;
    acc      = 1'b0;
    pathProp = 1'b1;
    for (int j = lo; j < nSlices; j++) begin
      acc      = acc | (pathProp & g[j]);
      pathProp = pathProp & p[j];
    end
    return acc | (pathProp & cin);
  endfunction

  always_comb begin
    for (int i = 0; i < nSlices; i++) begin
      sliceCarry[i] = groupCarry(i + 1, gen, prop, carryIn);
    end
    carryOut = groupCarry(0, gen, prop, carryIn);
  end

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= execStrobe;
    end
  end

  // Overflow when carry into bit 0 differs from carry out of it
  always_ff @(posedge eboxClk) begin
    if (execStrobe) begin
      resultData     <= adWord;
      resultCarry    <= carryOut;
      resultOverflow <= msbCarry ^ carryOut;
    end
  end

endmodule

//--- src/edpTop.sv
`timescale 1ns/100ps

module edpTop #(
  parameter int sliceWidth = 6
) (
  input  logic              eboxClk,
  input  logic              reset,

  input  logic              cmdStrobe,
  input  edpPkg::aluFuncT   cmdAluFunc,
  input  edpPkg::adaSelT    cmdAdaSel,
  input  edpPkg::adbSelT    cmdAdbSel,
  input  logic              cmdArLoad,
  input  logic              cmdBrLoad,
  input  edpPkg::mqFuncT    cmdMqFunc,
  input  edpPkg::wordT      cmdData,

  output logic              resultValid,
  output edpPkg::wordT      resultData,
  output logic              resultCarry,
  output logic              resultOverflow
);

  import edpPkg::*;

  localparam int nSlices = wordWidth / sliceWidth;

  adaSelT   adaSel;
  adbSelT   adbSel;
  logic     invertB;
  logic     arith;
  logicSelT logicSel;
  logic     carryIn;
  logic     arLoad;
  logic     brLoad;
  mqFuncT   mqFunc;
  wordT     opData;
  logic     execStrobe;
  wordT     adWord;

  logic [0:nSlices-1] sliceGen;
  logic [0:nSlices-1] sliceProp;
  logic [0:nSlices-1] sliceCarry;
  logic [0:nSlices-1] sliceMsbCarry;
  logic [0:nSlices-1] mqLow;
  logic [0:nSlices-1] mqIn;

  // MQ shift chain, AD bit 35 enters at the top of slice 0
  assign mqIn = {adWord[wordWidth-1], mqLow[0:nSlices-2]};

  edpControl control (
    .eboxClk    (eboxClk),
    .reset      (reset),
    .cmdStrobe  (cmdStrobe),
    .cmdAluFunc (cmdAluFunc),
    .cmdAdaSel  (cmdAdaSel),
    .cmdAdbSel  (cmdAdbSel),
    .cmdArLoad  (cmdArLoad),
    .cmdBrLoad  (cmdBrLoad),
    .cmdMqFunc  (cmdMqFunc),
    .cmdData    (cmdData),
    .adaSel     (adaSel),
    .adbSel     (adbSel),
    .invertB    (invertB),
    .arith      (arith),
    .logicSel   (logicSel),
    .carryIn    (carryIn),
    .arLoad     (arLoad),
    .brLoad     (brLoad),
    .mqFunc     (mqFunc),
    .opData     (opData),
    .execStrobe (execStrobe)
  );

  // Slice 0 holds bits 0 up to sliceWidth-1, the most significant end
  for (genvar i = 0; i < nSlices; i++) begin : slices
    edpSlice #(
      .sliceWidth (sliceWidth)
    ) slice (
      .eboxClk      (eboxClk),
      .reset        (reset),
      .adaSel       (adaSel),
      .adbSel       (adbSel),
      .invertB      (invertB),
      .arith        (arith),
      .logicSel     (logicSel),
      .arLoad       (arLoad),
      .brLoad       (brLoad),
      .mqFunc       (mqFunc),
      .sliceData    (opData[i*sliceWidth +: sliceWidth]),
      .sliceCarryIn (sliceCarry[i]),
      .mqShiftIn    (mqIn[i]),
      .gen          (sliceGen[i]),
      .prop         (sliceProp[i]),
      .msbCarry     (sliceMsbCarry[i]),
      .sliceAd      (adWord[i*sliceWidth +: sliceWidth]),
      .mqLow        (mqLow[i])
    );
  end

  edpLookahead #(
    .sliceWidth (sliceWidth)
  ) lookahead (
    .eboxClk        (eboxClk),
    .reset          (reset),
    .gen            (sliceGen),
    .prop           (sliceProp),
    .carryIn        (carryIn),
    .msbCarry       (sliceMsbCarry[0]),
    .adWord         (adWord),
    .execStrobe     (execStrobe),
    .sliceCarry     (sliceCarry),
    .resultValid    (resultValid),
    .resultData     (resultData),
    .resultCarry    (resultCarry),
    .resultOverflow (resultOverflow)
  );

endmodule

//--- bench/edpAsserts_asserts.sv
`timescale 1ns/100ps

module edpAsserts (
  input  logic             eboxClk,
  input  logic             reset,
  input  logic             cmdStrobe,
  input  edpPkg::aluFuncT  cmdAluFunc,
  input  logic             resultValid,
  input  edpPkg::wordT     resultData,
  input  logic             resultCarry,
  input  logic             resultOverflow
);

  import edpPkg::*;

  logic isLogic;

  assign isLogic = (cmdAluFunc != aluAdd) && (cmdAluFunc != aluSub);

  // Fixed latency of two edges from command to result
  latency: assert property (@(posedge eboxClk) disable iff (reset)
    resultValid == $past(cmdStrobe, 2))
    else $error("resultValid does not follow cmdStrobe by two edges");

  dataKnown: assert property (@(posedge eboxClk) disable iff (reset)
    resultValid |-> !$isunknown(resultData))
    else $error("resultData has unknown bits while resultValid is high");

  // Logic functions force generate and propagate low
  logicFlags: assert property (@(posedge eboxClk) disable iff (reset)
    (resultValid && $past(cmdStrobe & isLogic, 2)) |-> (!resultCarry && !resultOverflow))
    else $error("carry or overflow set on a logic function result");

endmodule

bind edpTop edpAsserts asserts (
  .eboxClk        (eboxClk),
  .reset          (reset),
  .cmdStrobe      (cmdStrobe),
  .cmdAluFunc     (cmdAluFunc),
  .resultValid    (resultValid),
  .resultData     (resultData),
  .resultCarry    (resultCarry),
  .resultOverflow (resultOverflow)
);

//--- bench/edpBench.sv
`timescale 1ns/100ps

module edpBench;

  import edpPkg::*;

  localparam int resetCycles = 16;
  // About 420 commands at four cycles each plus reset, doubled for margin
  localparam int cmdCount = 420;
  localparam int timeoutCycles = 2 * (resetCycles + 4 * cmdCount);

  logic eboxClk;
  logic reset;
  logic cmdStrobe;
  aluFuncT cmdAluFunc;
  adaSelT cmdAdaSel;
  adbSelT cmdAdbSel;
  logic cmdArLoad;
  logic cmdBrLoad;
  mqFuncT cmdMqFunc;
  wordT cmdData;
  logic resultValid;
  wordT resultData;
  logic resultCarry;
  logic resultOverflow;

  // Reference registers and expected results as {carry, overflow, data}
  wordT mAr = '0;
  wordT mBr = '0;
  wordT mMq = '0;
  logic [37:0] expQ[$];
  int issueQ[$];
  logic [31:0] lfsr = 32'h2940_827d;
  int cycles = 0;
  int checks = 0;
  int valueErrors = 0;
  int strobeErrors = 0;

  edpTop #(.sliceWidth(6)) UUT (
    .eboxClk(eboxClk), .reset(reset), .cmdStrobe(cmdStrobe), .cmdAluFunc(cmdAluFunc),
    .cmdAdaSel(cmdAdaSel), .cmdAdbSel(cmdAdbSel), .cmdArLoad(cmdArLoad),
    .cmdBrLoad(cmdBrLoad), .cmdMqFunc(cmdMqFunc), .cmdData(cmdData),
    .resultValid(resultValid), .resultData(resultData), .resultCarry(resultCarry),
    .resultOverflow(resultOverflow)
  );

  initial begin
    eboxClk = 1'b0;
    forever #50 eboxClk = ~eboxClk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randomBits(input int n, output logic [35:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = nextLfsr(lfsr);
      v = {v[34:0], lfsr[0]};
    end
  endtask

  // Drive one command and advance the reference model past it
  task automatic issue(input aluFuncT f, input adaSelT a, input adbSelT b,
                       input logic arLd, input logic brLd, input mqFuncT mf, input wordT d);
    wordT opA;
    wordT opB;
    wordT ad;
    logic [36:0] sum;
    logic [35:0] low;
    logic cin;
    logic carry;
    logic ovf;
    @(posedge eboxClk);
    cmdStrobe <= 1'b1;
    cmdAluFunc <= f;
    cmdAdaSel <= a;
    cmdAdbSel <= b;
    cmdArLoad <= arLd;
    cmdBrLoad <= brLd;
    cmdMqFunc <= mf;
    cmdData <= d;
    case (a)
      adaAr:   opA = mAr;
      adaMq:   opA = mMq;
      adaBr:   opA = mBr;
      default: opA = '0;
    endcase
    case (b)
      adbBr:   opB = mBr;
      adbData: opB = d;
      adbAr:   opB = mAr;
      default: opB = '0;
    endcase
    cin = (f == aluSub);
    carry = 1'b0;
    ovf = 1'b0;
    case (f)
      aluAdd, aluSub: begin
        if (cin) begin
          opB = ~opB;
        end
        sum = {1'b0, opA} + {1'b0, opB} + {36'b0, cin};
        // Carry into bit 0 from the 35 low bits
        low = {1'b0, opA[1:35]} + {1'b0, opB[1:35]} + {35'b0, cin};
        ad = sum[35:0];
        carry = sum[36];
        ovf = sum[36] ^ low[35];
      end
      aluAnd:    ad = opA & opB;
      aluAndNot: ad = opA & ~opB;
      aluOr:     ad = opA | opB;
      aluOrNot:  ad = opA | ~opB;
      aluXor:    ad = opA ^ opB;
      default:   ad = ~(opA ^ opB);
    endcase
    case (mf)
      mqLoadAd:     mMq = ad;
      mqShiftRight: mMq = {ad[35], mMq[0:34]};
      mqClear:      mMq = '0;
      default:      mMq = mMq;
    endcase
    if (brLd) begin
      mBr = mAr;
    end
    if (arLd) begin
      mAr = ad;
    end
    expQ.push_back({carry, ovf, ad});
    issueQ.push_back(cycles);
  endtask

  // Drop the strobe and wait until every result is back
  task automatic drain();
    @(posedge eboxClk);
    cmdStrobe <= 1'b0;
    while (issueQ.size() != 0) begin
      @(negedge eboxClk);
    end
  endtask

  task automatic runOne(input aluFuncT f, input adaSelT a, input adbSelT b,
                        input logic arLd, input logic brLd, input mqFuncT mf, input wordT d);
    issue(f, a, b, arLd, brLd, mf, d);
    drain();
  endtask

  // AR gets x and BR gets y, then f is applied to AR and BR
  task automatic pairOp(input aluFuncT f, input wordT x, input wordT y);
    runOne(aluAdd, adaZero, adbData, 1'b1, 1'b0, mqHold, y);
    runOne(aluAdd, adaZero, adbData, 1'b1, 1'b1, mqHold, x);
    runOne(f, adaAr, adbBr, 1'b0, 1'b0, mqHold, '0);
  endtask

  task automatic checkResult();
    logic [37:0] exp;
    int issued;
    if (expQ.size() == 0) begin
      strobeErrors++;
      $display("Result strobe at cycle %0d with no command outstanding", cycles);
    end else begin
      exp = expQ.pop_front();
      issued = issueQ.pop_front();
      checks++;
      assert (resultData === exp[35:0]) else begin
        valueErrors++;
        $display("Error %0t: resultData %h, expected %h", $time, resultData, exp[35:0]);
      end
      assert (resultCarry === exp[37]) else begin
        valueErrors++;
        $display("Error %0t: resultCarry %b, expected %b", $time, resultCarry, exp[37]);
      end
      assert (resultOverflow === exp[36]) else begin
        valueErrors++;
        $display("Error %0t: resultOverflow %b, expected %b", $time, resultOverflow, exp[36]);
      end
      // Strobe driven at edge n is sampled at n+1, result seen at n+3
      assert (cycles == issued + 3) else begin
        strobeErrors++;
        $display("Result strobe came %0d cycles after its command instead of 3", cycles - issued);
      end
    end
  endtask

  always @(posedge eboxClk) begin
    cycles <= cycles + 1;
    if (cycles >= timeoutCycles) begin
      $display("Timeout after %0d cycles with %0d results outstanding", cycles, expQ.size());
      $display("ERRORS FOUND");
      $finish;
    end else if (resultValid) begin
      checkResult();
    end else if (issueQ.size() != 0 && cycles > issueQ[0] + 3) begin
      strobeErrors++;
      $display("Result strobe missing for the command issued at cycle %0d", issueQ[0]);
      void'(issueQ.pop_front());
      void'(expQ.pop_front());
    end
  end

  task automatic resetTest();
    logic [35:0] x;
    runOne(aluAdd, adaAr, adbBr, 1'b0, 1'b0, mqHold, '0);
    randomBits(36, x);
    runOne(aluAdd, adaZero, adbData, 1'b1, 1'b0, mqHold, x);
    runOne(aluAdd, adaAr, adbZero, 1'b0, 1'b0, mqHold, '0);
  endtask

  task automatic arithTest();
    logic [35:0] x;
    logic [35:0] y;
    pairOp(aluAdd, '1, 36'd1);
    pairOp(aluSub, 36'h8_0000_0000, 36'd1);
    pairOp(aluSub, '0, '0);
    for (int i = 0; i < 30; i++) begin
      randomBits(36, x);
      randomBits(36, y);
      pairOp(aluAdd, x, y);
      pairOp(aluSub, x, y);
    end
  endtask

  task automatic logicTest();
    logic [35:0] x;
    logic [35:0] y;
    for (int k = 2; k < 8; k++) begin
      for (int i = 0; i < 8; i++) begin
        randomBits(36, x);
        randomBits(36, y);
        pairOp(aluFuncT'(k), x, y);
      end
    end
  endtask

  task automatic regTest();
    logic [35:0] x;
    randomBits(36, x);
    runOne(aluAdd, adaZero, adbData, 1'b1, 1'b0, mqHold, x);
    randomBits(36, x);
    // BR takes the old AR while AR loads new data
    runOne(aluAdd, adaZero, adbData, 1'b1, 1'b1, mqHold, x);
    runOne(aluAdd, adaBr, adbZero, 1'b0, 1'b0, mqHold, '0);
    runOne(aluAdd, adaAr, adbZero, 1'b0, 1'b0, mqHold, '0);
    randomBits(36, x);
    runOne(aluAdd, adaZero, adbData, 1'b0, 1'b0, mqLoadAd, x);
    for (int i = 0; i < 8; i++) begin
      randomBits(36, x);
      runOne(aluOr, adaZero, adbData, 1'b0, 1'b0, mqShiftRight, x);
      runOne(aluAdd, adaMq, adbZero, 1'b0, 1'b0, mqHold, '0);
    end
    runOne(aluAdd, adaZero, adbZero, 1'b0, 1'b0, mqClear, '0);
    runOne(aluAdd, adaMq, adbZero, 1'b0, 1'b0, mqHold, '0);
  endtask

  // Strobe on every cycle with random fields
  task automatic burstTest();
    logic [35:0] bits;
    logic [35:0] d;
    for (int i = 0; i < 60; i++) begin
      randomBits(11, bits);
      randomBits(36, d);
      issue(bits[2:0], bits[4:3], bits[6:5], bits[7], bits[8], bits[10:9], d);
    end
    drain();
  endtask

  initial begin
    reset = 1'b1;
    cmdStrobe = 1'b0;
    cmdAluFunc = aluAdd;
    cmdAdaSel = adaZero;
    cmdAdbSel = adbZero;
    cmdArLoad = 1'b0;
    cmdBrLoad = 1'b0;
    cmdMqFunc = mqHold;
    cmdData = '0;
    repeat (resetCycles) @(posedge eboxClk);
    reset <= 1'b0;
    resetTest();
    arithTest();
    logicTest();
    regTest();
    burstTest();
    // Catch any stray result strobe
    repeat (4) @(posedge eboxClk);
    $display("Checked %0d results, %0d value errors, %0d strobe errors",
             checks, valueErrors, strobeErrors);
    if (valueErrors + strobeErrors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- all.f
src/edpPkg.sv
src/edpControl.sv
src/edpSlice.sv
src/edpLookahead.sv
src/edpTop.sv
bench/edpAsserts_asserts.sv
bench/edpBench.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module edpBench -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/VedpBench)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
